// File: design/fetch_consts.svh
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// Width of addresses and instruction words
`define FETCH_XLEN 32

// Number of prefetch queue entries
`define FETCH_QUEUE_DEPTH 3

// Width of the interrupt index used for vectored traps
`define FETCH_IRQ_ID_WIDTH 5

// Upper mtvec bits, the base sits above bit 6
`define FETCH_MTVEC_WIDTH 25

// Fetch address held while in reset
`define FETCH_BOOT_RESET 32'h0000_0000

// addi x0, x0, 0
`define FETCH_NOP_WORD 32'h0000_0013

`endif

// File: design/fetch_pkg.sv
`include "fetch_consts.svh"

package fetch_pkg;

  // Source of the next fetch address on a redirect
  typedef enum logic [3:0] {
    PC_BOOT     = 4'd0,
    PC_JUMP     = 4'd1,
    PC_BRANCH   = 4'd2,
    PC_MRET     = 4'd3,
    PC_TRAP_EXC = 4'd4,
    PC_TRAP_IRQ = 4'd5
  } pc_mux_e;

  // Four-phase bus master states
  typedef enum logic [1:0] {
    IDLE         = 2'd0,
    REQ          = 2'd1,
    WAIT_ACK_LOW = 2'd2
  } bus_state_e;

  // Redirect target addresses from the rest of the core
  typedef struct packed {
    logic [`FETCH_XLEN-1:0]        boot;
    logic [`FETCH_XLEN-1:0]        jump;
    logic [`FETCH_XLEN-1:0]        branch;
    logic [`FETCH_XLEN-1:0]        mepc;
    logic [`FETCH_MTVEC_WIDTH-1:0] mtvec;
  } fetch_targets_t;

  // Control from the controller FSM
  typedef struct packed {
    logic                           pc_set;
    pc_mux_e                        pc_mux;
    logic                           halt_if;
    logic                           kill_if;
    logic [`FETCH_IRQ_ID_WIDTH-1:0] irq_index;
  } fetch_ctrl_t;

  // One fetched word as held in the queue
  typedef struct packed {
    logic [`FETCH_XLEN-1:0] pc;
    logic [`FETCH_XLEN-1:0] rdata;
    logic                   err;
  } fetch_entry_t;

  // Contents of the IF/ID pipeline register
  typedef struct packed {
    logic                   instr_valid;
    logic [`FETCH_XLEN-1:0] pc;
    logic [`FETCH_XLEN-1:0] instr;
    logic                   abort_op;
  } if_id_pipe_t;

endpackage

// File: design/fetch_addr_gen.sv
`timescale 1ns/1ns
`include "fetch_consts.svh"

module fetch_addr_gen (
  input  logic                     clk,
  input  logic                     rst_n,
  input  fetch_pkg::fetch_ctrl_t   ctrl_i,
  input  fetch_pkg::fetch_targets_t targets_i,
  input  logic                     advance_i,
  output logic [`FETCH_XLEN-1:0]   fetch_addr_o,
  output logic                     mtvec_init_o
);

  logic [`FETCH_XLEN-1:0] target;

  //////////////////////////////////////////////////////////////////////
  // Redirect target selection
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    // Boot target doubles as the fallback
    target = {targets_i.boot[`FETCH_XLEN-1:2], 2'b00};
    case (ctrl_i.pc_mux)
      fetch_pkg::PC_BOOT:     target = {targets_i.boot[`FETCH_XLEN-1:2], 2'b00};
      fetch_pkg::PC_JUMP:     target = targets_i.jump;
      fetch_pkg::PC_BRANCH:   target = targets_i.branch;
      // Return from trap restores the saved PC
      fetch_pkg::PC_MRET:     target = targets_i.mepc;
      // Exceptions share the base address
      fetch_pkg::PC_TRAP_EXC: target = {targets_i.mtvec, 7'b000_0000};
      // Interrupts are vectored, one word per index
      fetch_pkg::PC_TRAP_IRQ: target = {targets_i.mtvec, ctrl_i.irq_index, 2'b00};
      default: ;
    endcase
  end

  // mtvec gets initialised while the boot redirect is applied
  assign mtvec_init_o = ctrl_i.pc_set && (ctrl_i.pc_mux == fetch_pkg::PC_BOOT);

  // Redirect wins over sequential stepping
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fetch_addr_o <= `FETCH_BOOT_RESET;
    end else if (ctrl_i.pc_set) begin
      fetch_addr_o <= target;
    end else if (advance_i) begin
      fetch_addr_o <= fetch_addr_o + `FETCH_XLEN'd4;
    end
  end

  // Targets from outside must keep fetches word aligned
  a_addr_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    fetch_addr_o[1:0] == 2'b00);

endmodule

// File: design/fetch_bus_master.sv
`timescale 1ns/1ns
`include "fetch_consts.svh"

module fetch_bus_master (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    flush_i,
  input  logic [`FETCH_XLEN-1:0]  fetch_addr_i,
  input  logic                    credit_i,
  output logic                    instr_req_o,
  output logic [`FETCH_XLEN-1:0]  instr_addr_o,
  input  logic                    instr_ack_i,
  input  logic [`FETCH_XLEN-1:0]  instr_rdata_i,
  input  logic                    instr_err_i,
  output logic                    advance_o,
  output logic                    push_o,
  output fetch_pkg::fetch_entry_t entry_o,
  output logic                    busy_o
);

  fetch_pkg::bus_state_e state_q;
  fetch_pkg::bus_state_e state_d;
  logic                  discard_q;
  // No fetching until the first redirect has set a valid address
  logic                  armed_q;
  logic                  can_issue;
  logic                  resp_taken;

  // Never start on the old address while a redirect is applied
  assign can_issue  = armed_q && credit_i && !flush_i;
  assign resp_taken = (state_q == fetch_pkg::REQ) && instr_ack_i;

  //////////////////////////////////////////////////////////////////////
  // Four-phase handshake FSM
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d   = state_q;
    advance_o = 1'b0;
    case (state_q)
      fetch_pkg::IDLE: begin
        if (can_issue && !instr_ack_i) begin
          state_d   = fetch_pkg::REQ;
          advance_o = 1'b1;
        end
      end
      // Hold req and address until memory answers
      fetch_pkg::REQ: begin
        if (instr_ack_i) begin
          state_d = fetch_pkg::WAIT_ACK_LOW;
        end
      end
      // Ack seen low here, so the next req may follow directly
      fetch_pkg::WAIT_ACK_LOW: begin
        if (!instr_ack_i) begin
          if (can_issue) begin
            state_d   = fetch_pkg::REQ;
            advance_o = 1'b1;
          end else begin
            state_d = fetch_pkg::IDLE;
          end
        end
      end
      default: state_d = fetch_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q   <= fetch_pkg::IDLE;
      discard_q <= 1'b0;
      armed_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      if (flush_i) begin
        armed_q <= 1'b1;
      end
      // Response of a redirected request is dropped
      if (resp_taken) begin
        discard_q <= 1'b0;
      end else if (flush_i && (state_q == fetch_pkg::REQ)) begin
        discard_q <= 1'b1;
      end
    end
  end

  // Request address, latched as the address generator steps
  always_ff @(posedge clk) begin
    if (advance_o) begin
      instr_addr_o <= fetch_addr_i;
    end
  end

  assign instr_req_o = (state_q == fetch_pkg::REQ);
  assign busy_o      = (state_q != fetch_pkg::IDLE);

  // Data sampled on the first ack cycle
  assign push_o  = resp_taken && !discard_q && !flush_i;
  assign entry_o = '{pc: instr_addr_o, rdata: instr_rdata_i, err: instr_err_i};

  a_req_until_ack: assert property (@(posedge clk) disable iff (!rst_n)
    instr_req_o && !instr_ack_i |=> instr_req_o);

  a_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
    instr_req_o && !instr_ack_i |=> $stable(instr_addr_o));

  a_no_req_on_ack: assert property (@(posedge clk) disable iff (!rst_n)
    !instr_req_o && instr_ack_i |=> !instr_req_o);

endmodule

// File: design/fetch_queue.sv
`timescale 1ns/1ns
`include "fetch_consts.svh"

module fetch_queue (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    flush_i,
  input  logic                    push_i,
  input  fetch_pkg::fetch_entry_t entry_i,
  input  logic                    in_flight_i,
  input  logic                    pop_i,
  output logic                    credit_o,
  output fetch_pkg::fetch_entry_t head_o,
  output logic                    head_valid_o
);

  localparam int DEPTH = `FETCH_QUEUE_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  fetch_pkg::fetch_entry_t mem_q [DEPTH];
  logic [PTR_W-1:0]        wr_ptr_q;
  logic [PTR_W-1:0]        rd_ptr_q;
  logic [CNT_W-1:0]        count_q;
  // Entries held plus the one still on the bus
  logic [CNT_W:0]          occupancy;

  // Circular pointer step
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign occupancy    = {1'b0, count_q} + {{CNT_W{1'b0}}, in_flight_i};
  assign credit_o     = occupancy < DEPTH;
  assign head_valid_o = (count_q != '0);
  assign head_o       = mem_q[rd_ptr_q];

  //////////////////////////////////////////////////////////////////////
  // Pointers and fill count
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      // Redirect empties the queue
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (pop_i) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;
      endcase
    end
  end

  // Entry storage
  always_ff @(posedge clk) begin
    if (push_i && !flush_i) begin
      mem_q[wr_ptr_q] <= entry_i;
    end
  end

  // Credit at the bus master and head_valid at IF/ID keep this safe
  a_no_overrun: assert property (@(posedge clk) disable iff (!rst_n)
    !(push_i && (count_q == CNT_W'(DEPTH))) && !(pop_i && (count_q == '0)));

endmodule

// File: design/if_id_stage.sv
`timescale 1ns/1ns
`include "fetch_consts.svh"

module if_id_stage (
  input  logic                    clk,
  input  logic                    rst_n,
  input  fetch_pkg::fetch_ctrl_t  ctrl_i,
  input  fetch_pkg::fetch_entry_t head_i,
  input  logic                    head_valid_i,
  input  logic                    id_ready_i,
  output logic                    pop_o,
  output logic                    if_valid_o,
  output logic [`FETCH_XLEN-1:0]  pc_if_o,
  output fetch_pkg::if_id_pipe_t  if_id_pipe_o
);

  logic if_ready;

  //////////////////////////////////////////////////////////////////////
  // Handshake towards ID
  //////////////////////////////////////////////////////////////////////

  // Nothing goes to ID while halted, killed or redirecting
  assign if_valid_o = head_valid_i && !ctrl_i.kill_if && !ctrl_i.halt_if && !ctrl_i.pc_set;

  // Kill drains the head regardless of ID
  assign if_ready = ctrl_i.kill_if || (id_ready_i && !ctrl_i.halt_if);

  assign pop_o   = head_valid_i && if_ready;
  assign pc_if_o = head_i.pc;

  //////////////////////////////////////////////////////////////////////
  // IF/ID register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      if_id_pipe_o.instr_valid <= 1'b0;
      if_id_pipe_o.pc          <= `FETCH_BOOT_RESET;
      if_id_pipe_o.instr       <= `FETCH_NOP_WORD;
      if_id_pipe_o.abort_op    <= 1'b0;
    end else if (if_valid_o && id_ready_i) begin
      if_id_pipe_o.instr_valid <= 1'b1;
      if_id_pipe_o.pc          <= head_i.pc;
      if_id_pipe_o.instr       <= head_i.rdata;
      // Bus error turns the operation into an aborted one
      if_id_pipe_o.abort_op    <= head_i.err;
    end else if (id_ready_i) begin
      // ID took the old one and nothing new came
      if_id_pipe_o.instr_valid <= 1'b0;
    end
    // Otherwise ID is stalled and the register holds
  end

endmodule

// File: design/fetch_stage.sv
`timescale 1ns/1ns
`include "fetch_consts.svh"

module fetch_stage (
  input  logic                      clk,
  input  logic                      rst_n,
  input  fetch_pkg::fetch_ctrl_t    ctrl_i,
  input  fetch_pkg::fetch_targets_t targets_i,
  // Instruction bus
  output logic                      instr_req_o,
  output logic [`FETCH_XLEN-1:0]    instr_addr_o,
  input  logic                      instr_ack_i,
  input  logic [`FETCH_XLEN-1:0]    instr_rdata_i,
  input  logic                      instr_err_i,
  // ID side
  input  logic                      id_ready_i,
  output fetch_pkg::if_id_pipe_t    if_id_pipe_o,
  output logic                      if_valid_o,
  output logic [`FETCH_XLEN-1:0]    pc_if_o,
  output logic                      csr_mtvec_init_o,
  output logic                      if_busy_o
);

  logic [`FETCH_XLEN-1:0]  fetch_addr;
  logic                    advance;
  logic                    credit;
  logic                    push;
  fetch_pkg::fetch_entry_t entry;
  fetch_pkg::fetch_entry_t head;
  logic                    head_valid;
  logic                    pop;

  // Next address and redirect targets
  fetch_addr_gen addr_gen_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .ctrl_i       (ctrl_i),
    .targets_i    (targets_i),
    .advance_i    (advance),
    .fetch_addr_o (fetch_addr),
    .mtvec_init_o (csr_mtvec_init_o)
  );

  // Single outstanding bus request, flushed on redirect
  fetch_bus_master bus_master_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .flush_i       (ctrl_i.pc_set),
    .fetch_addr_i  (fetch_addr),
    .credit_i      (credit),
    .instr_req_o   (instr_req_o),
    .instr_addr_o  (instr_addr_o),
    .instr_ack_i   (instr_ack_i),
    .instr_rdata_i (instr_rdata_i),
    .instr_err_i   (instr_err_i),
    .advance_o     (advance),
    .push_o        (push),
    .entry_o       (entry),
    .busy_o        (if_busy_o)
  );

  // req high means one word is on its way into the queue
  fetch_queue queue_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush_i      (ctrl_i.pc_set),
    .push_i       (push),
    .entry_i      (entry),
    .in_flight_i  (instr_req_o),
    .pop_i        (pop),
    .credit_o     (credit),
    .head_o       (head),
    .head_valid_o (head_valid)
  );

  if_id_stage if_id_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .ctrl_i       (ctrl_i),
    .head_i       (head),
    .head_valid_i (head_valid),
    .id_ready_i   (id_ready_i),
    .pop_o        (pop),
    .if_valid_o   (if_valid_o),
    .pc_if_o      (pc_if_o),
    .if_id_pipe_o (if_id_pipe_o)
  );

endmodule

// File: testbench/fetch_checker.sv
`timescale 1ns/1ns
`include "fetch_consts.svh"

module fetch_checker (
  input  logic                      clk,
  input  logic                      rst_n,
  input  fetch_pkg::fetch_ctrl_t    ctrl_i,
  input  fetch_pkg::fetch_targets_t targets_i,
  input  logic                      id_ready_i,
  input  logic                      instr_req_i,
  input  logic                      if_valid_i,
  input  logic [`FETCH_XLEN-1:0]    pc_if_i,
  input  logic                      csr_mtvec_init_i,
  input  logic                      if_busy_i,
  input  fetch_pkg::if_id_pipe_t    if_id_pipe_i,
  input  logic [31:0]               mem_i [64],
  input  logic [63:0]               err_mask_i,
  output int                        error_count_o,
  output int                        check_count_o,
  output int                        delivered_o
);

  // Next PC that ID should see
  logic [31:0]            exp_pc;
  logic                   booted;
  logic                   load_pending;
  logic                   prev_ready;
  fetch_pkg::if_id_pipe_t prev_pipe;

  initial begin
    error_count_o = 0;
    check_count_o = 0;
    delivered_o   = 0;
  end

  // Target address as defined for each redirect source
  function automatic logic [31:0] redirect_target(input fetch_pkg::fetch_ctrl_t c,
                                                  input fetch_pkg::fetch_targets_t t);
    case (c.pc_mux)
      fetch_pkg::PC_BOOT:     return t.boot & 32'hffff_fffc;
      fetch_pkg::PC_JUMP:     return t.jump;
      fetch_pkg::PC_BRANCH:   return t.branch;
      fetch_pkg::PC_MRET:     return t.mepc;
      fetch_pkg::PC_TRAP_EXC: return {t.mtvec, 7'd0};
      // One word per interrupt above the base
      fetch_pkg::PC_TRAP_IRQ: return {t.mtvec, 7'd0} + 32'(c.irq_index) * 4;
      default:                return 32'hxxxx_xxxx;
    endcase
  endfunction

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    check_count_o = check_count_o + 1;
    if (got !== exp) begin
      error_count_o = error_count_o + 1;
      $display("error %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_true(input string what, input logic ok);
    check_count_o = check_count_o + 1;
    if (ok !== 1'b1) begin
      error_count_o = error_count_o + 1;
      $display("error %0t: %s", $time, what);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Sampling at the falling edge where all signals have settled
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (!rst_n) begin
      check_true("outputs low in reset", !instr_req_i && !if_valid_i && !csr_mtvec_init_i
                 && !if_busy_i && !if_id_pipe_i.instr_valid);
      booted       = 1'b0;
      load_pending = 1'b0;
      prev_ready   = 1'b1;
      exp_pc       = '0;
    end else begin
      // Load at the last rising edge
      if (load_pending) begin
        check_true("instr_valid set after a load", if_id_pipe_i.instr_valid);
        check_value("delivered pc", if_id_pipe_i.pc, exp_pc);
        check_value("delivered word", if_id_pipe_i.instr, mem_i[exp_pc[7:2]]);
        check_value("abort_op", {31'd0, if_id_pipe_i.abort_op},
                    {31'd0, err_mask_i[exp_pc[7:2]]});
        exp_pc      = exp_pc + 32'd4;
        delivered_o = delivered_o + 1;
      end else if (prev_ready) begin
        // ID was ready and nothing new came in
        check_true("instr_valid kept with nothing new loaded", !if_id_pipe_i.instr_valid);
      end
      // Stalled ID keeps the register untouched
      if (!prev_ready) begin
        check_true("IF/ID register changed while ID stalled", if_id_pipe_i === prev_pipe);
      end
      check_true("csr_mtvec_init_o does not follow the boot redirect",
                 csr_mtvec_init_i == (ctrl_i.pc_set && ctrl_i.pc_mux == fetch_pkg::PC_BOOT));
      if (!booted) begin
        check_true("fetch activity before the first redirect",
                   !instr_req_i && !if_valid_i && !if_busy_i);
      end
      // A request on the bus keeps the fetch stage busy
      if (instr_req_i) begin
        check_true("if_busy_o low while a request is open", if_busy_i);
      end
      if (ctrl_i.halt_if) begin
        check_true("if_valid_o high while halted", !if_valid_i);
      end
      if (if_valid_i) begin
        check_value("pc_if_o", pc_if_i, exp_pc);
      end
      if (ctrl_i.pc_set) begin
        check_true("if_valid_o high during a redirect", !if_valid_i);
        exp_pc = redirect_target(ctrl_i, targets_i);
        booted = 1'b1;
      end
      load_pending = if_valid_i && id_ready_i;
      prev_ready   = id_ready_i;
      prev_pipe    = if_id_pipe_i;
    end
  end

endmodule

// File: testbench/tb_fetch_stage.sv
`timescale 1ns/1ns
`include "fetch_consts.svh"

module tb_fetch_stage;

  // Sections of the data file
  localparam int MEM_WORDS = 64;
  localparam int MASK_BASE = 'h40;
  localparam int CMD_BASE  = 'h48;
  localparam int DATA_SIZE = 256;

  logic                      clk;
  logic                      rst_n;
  fetch_pkg::fetch_ctrl_t    ctrl_i;
  fetch_pkg::fetch_targets_t targets_i;
  logic                      instr_req_o;
  logic [`FETCH_XLEN-1:0]    instr_addr_o;
  logic                      instr_ack_i;
  logic [`FETCH_XLEN-1:0]    instr_rdata_i;
  logic                      instr_err_i;
  logic                      id_ready_i;
  fetch_pkg::if_id_pipe_t    if_id_pipe_o;
  logic                      if_valid_o;
  logic [`FETCH_XLEN-1:0]    pc_if_o;
  logic                      csr_mtvec_init_o;
  logic                      if_busy_o;

  logic [31:0] tdata [DATA_SIZE];
  logic [31:0] mem [MEM_WORDS];
  logic [63:0] err_mask;
  integer      seed;
  int          cmd_count;
  int          error_count;
  int          check_count;
  int          delivered;
  // Memory side of the handshake
  logic        waiting;
  int          ack_delay;

  initial clk = 1'b0;
  always #5 clk = ~clk;

  fetch_stage fetch_stage_i (
    .clk              (clk),
    .rst_n            (rst_n),
    .ctrl_i           (ctrl_i),
    .targets_i        (targets_i),
    .instr_req_o      (instr_req_o),
    .instr_addr_o     (instr_addr_o),
    .instr_ack_i      (instr_ack_i),
    .instr_rdata_i    (instr_rdata_i),
    .instr_err_i      (instr_err_i),
    .id_ready_i       (id_ready_i),
    .if_id_pipe_o     (if_id_pipe_o),
    .if_valid_o       (if_valid_o),
    .pc_if_o          (pc_if_o),
    .csr_mtvec_init_o (csr_mtvec_init_o),
    .if_busy_o        (if_busy_o)
  );

  fetch_checker checker_i (
    .clk              (clk),
    .rst_n            (rst_n),
    .ctrl_i           (ctrl_i),
    .targets_i        (targets_i),
    .id_ready_i       (id_ready_i),
    .instr_req_i      (instr_req_o),
    .if_valid_i       (if_valid_o),
    .pc_if_i          (pc_if_o),
    .csr_mtvec_init_i (csr_mtvec_init_o),
    .if_busy_i        (if_busy_o),
    .if_id_pipe_i     (if_id_pipe_o),
    .mem_i            (mem),
    .err_mask_i       (err_mask),
    .error_count_o    (error_count),
    .check_count_o    (check_count),
    .delivered_o      (delivered)
  );

  //////////////////////////////////////////////////////////////////////
  // Four-phase memory with random ack delay
  //////////////////////////////////////////////////////////////////////

  always begin
    @(posedge clk);
    #2;
    if (!rst_n) begin
      instr_ack_i = 1'b0;
      waiting     = 1'b0;
    end else if (instr_ack_i) begin
      // Master has sampled and dropped req
      instr_ack_i = 1'b0;
    end else if (instr_req_o) begin
      if (!waiting) begin
        waiting   = 1'b1;
        ack_delay = $random(seed) & 3;
      end
      if (ack_delay == 0) begin
        instr_ack_i   = 1'b1;
        instr_rdata_i = mem[instr_addr_o[7:2]];
        instr_err_i   = err_mask[instr_addr_o[7:2]];
        waiting       = 1'b0;
      end else begin
        ack_delay = ack_delay - 1;
      end
    end
  end

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  // Random targets with the selected one taken from the command
  task automatic load_targets(input logic [31:0] cmd);
    logic [31:0] value;
    logic [31:0] rnd;
    value = {20'd0, cmd[11:0]};
    targets_i.boot   = $random(seed);
    targets_i.jump   = $random(seed) & 32'hffff_fffc;
    targets_i.branch = $random(seed) & 32'hffff_fffc;
    targets_i.mepc   = $random(seed) & 32'hffff_fffc;
    rnd              = $random(seed);
    targets_i.mtvec  = rnd[31:7];
    case (fetch_pkg::pc_mux_e'(cmd[27:24]))
      fetch_pkg::PC_BOOT:   targets_i.boot = value;
      fetch_pkg::PC_JUMP:   targets_i.jump = value;
      fetch_pkg::PC_BRANCH: targets_i.branch = value;
      fetch_pkg::PC_MRET:   targets_i.mepc = value;
      default:              targets_i.mtvec = value[31:7];
    endcase
  endtask

  task automatic run_command(input logic [31:0] cmd);
    int cycles;
    cycles = cmd[19:12];
    case (cmd[31:28])
      4'h1: begin
        load_targets(cmd);
        ctrl_i.pc_set    = 1'b1;
        ctrl_i.pc_mux    = fetch_pkg::pc_mux_e'(cmd[27:24]);
        ctrl_i.kill_if   = cmd[20];
        ctrl_i.irq_index = cmd[6:2];
        next_cycle();
        ctrl_i.pc_set  = 1'b0;
        ctrl_i.kill_if = 1'b0;
        repeat (cycles) next_cycle();
      end
      4'h2: begin
        ctrl_i.halt_if = 1'b1;
        repeat (cycles) next_cycle();
        ctrl_i.halt_if = 1'b0;
      end
      4'h3: begin
        id_ready_i = 1'b0;
        repeat (cycles) next_cycle();
        id_ready_i = 1'b1;
      end
      default: repeat (cycles) next_cycle();
    endcase
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    rst_n         = 1'b0;
    ctrl_i        = '0;
    targets_i     = '0;
    id_ready_i    = 1'b1;
    instr_ack_i   = 1'b0;
    instr_rdata_i = '0;
    instr_err_i   = 1'b0;
    seed          = 32'h2753;
    $readmemh("testbench/fetch_testdata.txt", tdata);
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = tdata[i];
    end
    err_mask  = {tdata[MASK_BASE+1], tdata[MASK_BASE]};
    cmd_count = 0;
    while (CMD_BASE + cmd_count < DATA_SIZE && tdata[CMD_BASE+cmd_count][31:28] != 4'h0) begin
      cmd_count = cmd_count + 1;
    end
    repeat (16) @(posedge clk);
    #2;
    rst_n = 1'b1;
    for (int k = 0; k < cmd_count; k++) begin
      run_command(tdata[CMD_BASE+k]);
    end
    repeat (4) next_cycle();
    if (delivered == 0) begin
      $display("No instruction ever reached the IF/ID register");
    end
    $display("Summary: %0d checks, %0d errors, %0d instructions delivered",
             check_count, error_count, delivered);
    if (error_count == 0 && delivered > 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // Budget grows with the number of commands
  initial begin
    #1;
    repeat (200 * cmd_count + 500) @(posedge clk);
    $display("Timeout: the command sequence did not finish in %0d cycles",
             200 * cmd_count + 500);
    $display("Testbench failed");
    $finish;
  end

endmodule

// File: flist.f
+incdir+design
design/fetch_pkg.sv
design/fetch_addr_gen.sv
design/fetch_bus_master.sv
design/fetch_queue.sv
design/if_id_stage.sv
design/fetch_stage.sv
testbench/fetch_checker.sv
testbench/tb_fetch_stage.sv

// File: Bender.yml
package:
  name: fetch_stage

sources:
  - include_dirs:
      - design
    files:
      - design/fetch_pkg.sv
      - design/fetch_addr_gen.sv
      - design/fetch_bus_master.sv
      - design/fetch_queue.sv
      - design/if_id_stage.sv
      - design/fetch_stage.sv
  - target: test
    include_dirs:
      - design
    files:
      - testbench/fetch_checker.sv
      - testbench/tb_fetch_stage.sv

// File: testbench/fetch_testdata.txt
// Words 00-3f: memory image. @40: error mask, bit n marks word n (00-1f, then 20-3f)
// @48: commands, op[31:28] mux[27:24] kill[20] cycles[19:12] value[11:0], op 0 ends
@00
00000013 01010113 02020213 03030313 04040413 05050513 06060613 07070713
08080813 09090913 0a0a0a13 0b0b0b13 0c0c0c13 0d0d0d13 0e0e0e13 0f0f0f13
10101013 11111113 12121213 13131313 14141413 15151513 16161613 17171713
18181813 19191913 1a1a1a13 1b1b1b13 1c1c1c13 1d1d1d13 1e1e1e13 1f1f1f13
20202013 21212113 22222213 23232313 24242413 25252513 26262613 27272713
28282813 29292913 2a2a2a13 2b2b2b13 2c2c2c13 2d2d2d13 2e2e2e13 2f2f2f13
30303013 31313113 32323213 33333313 34343413 35353513 36363613 37373713
38383813 39393913 3a3a3a13 3b3b3b13 3c3c3c13 3d3d3d13 3e3e3e13 3f3f3f13
@40 00040080 04000002
@48
4000c000 10128002 30009000 4000f000 // idle, unaligned boot, ID stall, run
11120084 2000a000 121301e0 13114040 // jump, halt, branch across wrap, mret
14118180 30006000 151200a4 111020c0 // trap, ID stall, vectored irq 9, short jump
121280f0 40010000 00000000          // branch, drain, end
